//--- chi_home_macros.svh
`ifndef CHI_HOME_MACROS_SVH
`define CHI_HOME_MACROS_SVH

// ==============================
// Home node sizing
// ==============================

// Request address width
`define CHI_ADDR_W 32
// Transaction id width
`define CHI_TXN_W 8
// Requesting nodes, also the sharer mask width
`define CHI_NUM_NODES 8
// Node id width
`define CHI_NODE_W 3
// log2 of the cache line size in bytes
`define CHI_LINE_OFS 6
// Directory index width, 64 entries
`define CHI_DIR_IDX_W 6
// Performance counter width
`define CHI_CNT_W 32

`endif

//--- chi_home_pkg.sv
package chi_home_pkg;

  // ==============================
  // Channel opcodes
  // ==============================

  // Coherent read requests from a requesting node
  typedef enum logic [1:0] {
    READ_SHARED = 2'd0,
    READ_UNIQUE = 2'd1
  } chi_req_op_e;

  // Snoops sent by the home node
  typedef enum logic [1:0] {
    SNP_SHARED = 2'd0,
    SNP_UNIQUE = 2'd1
  } chi_snp_op_e;

  // Completion types
  typedef enum logic [1:0] {
    COMP     = 2'd0,
    COMP_ERR = 2'd1
  } chi_resp_op_e;

  // ==============================
  // Directory and controller state
  // ==============================

  // Line state kept per directory entry
  typedef enum logic [1:0] {
    INVALID      = 2'd0,
    SHARED_CLEAN = 2'd1,
    UNIQUE_CLEAN = 2'd2
  } chi_line_state_e;

  // Transaction FSM states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOOKUP    = 3'd1,
    SNOOP     = 3'd2,
    AWAIT_SNP = 3'd3,
    COMPLETE  = 3'd4,
    ERROR     = 3'd5
  } chi_ctrl_state_e;

endpackage

//--- chi_req_intake.sv
`timescale 1ns/1ps
`include "chi_home_macros.svh"

module chi_req_intake (
  input  logic                          clk,
  input  logic                          rst_n,
  // Request channel from the requesting nodes
  input  logic                          req_valid,
  output logic                          req_ready,
  input  chi_home_pkg::chi_req_op_e     req_op,
  input  logic [`CHI_TXN_W-1:0]         req_txn_id,
  input  logic [`CHI_NODE_W-1:0]        req_src_id,
  input  logic [`CHI_ADDR_W-1:0]        req_addr,
  // Managed address window
  input  logic [`CHI_ADDR_W-1:0]        base_addr,
  input  logic [`CHI_ADDR_W-1:0]        addr_mask,
  input  chi_home_pkg::chi_ctrl_state_e state,
  // To the controller
  output logic                          accept,
  output logic                          in_range,
  // Captured request
  output chi_home_pkg::chi_req_op_e     cur_op,
  output logic [`CHI_TXN_W-1:0]         cur_txn_id,
  output logic [`CHI_NODE_W-1:0]        cur_src_id,
  output logic [`CHI_ADDR_W-1:0]        cur_addr
);

  // ==============================
  // Handshake
  // ==============================

  // Only one transaction in flight, so take a new one only in IDLE
  assign req_ready = (state == chi_home_pkg::IDLE);
  assign accept    = req_valid && req_ready;

  // Window check on the incoming address
  // The controller samples this on the accept cycle to pick LOOKUP or ERROR
  assign in_range = ((req_addr & addr_mask) == (base_addr & addr_mask));

  // ==============================
  // Request capture
  // ==============================

  // Fields stay put until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_op     <= req_op;
      cur_txn_id <= req_txn_id;
      cur_src_id <= req_src_id;
      cur_addr   <= req_addr;
    end
  end

endmodule

//--- chi_directory.sv
`timescale 1ns/1ps
`include "chi_home_macros.svh"

module chi_directory (
  input  logic                          clk,
  input  logic                          rst_n,
  input  chi_home_pkg::chi_ctrl_state_e state,
  // Captured request
  input  chi_home_pkg::chi_req_op_e     cur_op,
  input  logic [`CHI_NODE_W-1:0]        cur_src_id,
  input  logic [`CHI_ADDR_W-1:0]        cur_addr,
  // Write strobe from the controller
  input  logic                          dir_update,
  // Lookup results
  output logic                          snoop_needed,
  output logic [`CHI_NUM_NODES-1:0]     snp_tgt_mask,
  output logic                          dir_hit,
  output chi_home_pkg::chi_line_state_e granted_state
);

  // ==============================
  // Storage
  // ==============================

  // Direct mapped, one entry per line index
  logic                          valid_mem   [0:(1 << `CHI_DIR_IDX_W)-1];
  logic [`CHI_NUM_NODES-1:0]     sharers_mem [0:(1 << `CHI_DIR_IDX_W)-1];
  chi_home_pkg::chi_line_state_e state_mem   [0:(1 << `CHI_DIR_IDX_W)-1];

  logic [`CHI_DIR_IDX_W-1:0]     idx;
  logic [`CHI_NUM_NODES-1:0]     req_bit;
  logic [`CHI_NUM_NODES-1:0]     others;
  chi_home_pkg::chi_line_state_e line_state;

  // Index taken just above the line offset
  assign idx        = cur_addr[`CHI_LINE_OFS +: `CHI_DIR_IDX_W];
  assign req_bit    = {{(`CHI_NUM_NODES-1){1'b0}}, 1'b1} << cur_src_id;
  assign line_state = state_mem[idx];

  // Sharers excluding the requester itself
  assign others = sharers_mem[idx] & ~req_bit;

  // ==============================
  // Snoop targets
  // ==============================

  always_comb begin
    snp_tgt_mask = '0;
    if (cur_op == chi_home_pkg::READ_UNIQUE) begin
      // Every other copy must be invalidated
      snp_tgt_mask = others;
    end else if (line_state == chi_home_pkg::UNIQUE_CLEAN) begin
      // Shared read only disturbs a unique owner
      snp_tgt_mask = others;
    end
  end

  assign snoop_needed = |snp_tgt_mask;
  assign dir_hit      = (state == chi_home_pkg::LOOKUP) && valid_mem[idx];

  // State written back on completion
  assign granted_state = (cur_op == chi_home_pkg::READ_UNIQUE) ?
                         chi_home_pkg::UNIQUE_CLEAN : chi_home_pkg::SHARED_CLEAN;

  // ==============================
  // Update
  // ==============================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < (1 << `CHI_DIR_IDX_W); i++) begin
        valid_mem[i]   <= 1'b0;
        sharers_mem[i] <= '0;
        state_mem[i]   <= chi_home_pkg::INVALID;
      end
    end else if (dir_update) begin
      valid_mem[idx] <= 1'b1;
      state_mem[idx] <= granted_state;
      if (cur_op == chi_home_pkg::READ_UNIQUE) begin
        // Requester becomes the sole holder
        sharers_mem[idx] <= req_bit;
      end else begin
        sharers_mem[idx] <= sharers_mem[idx] | req_bit;
      end
    end
  end

endmodule

//--- chi_home_ctrl.sv
`timescale 1ns/1ps

module chi_home_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  // Request side
  input  logic                          accept,
  input  logic                          in_range,
  // Directory result
  input  logic                          snoop_needed,
  // Channel handshakes
  input  logic                          snp_ready,
  input  logic                          snp_resp_valid,
  input  logic                          resp_ready,
  // Outputs
  output chi_home_pkg::chi_ctrl_state_e state,
  output logic                          dir_update
);

  chi_home_pkg::chi_ctrl_state_e state_nxt;

  // ==============================
  // State register
  // ==============================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= chi_home_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ==============================
  // Next state
  // ==============================

  always_comb begin
    state_nxt = state;
    case (state)
      chi_home_pkg::IDLE: begin
        // Range decides between normal flow and error reply
        if (accept) begin
          state_nxt = in_range ? chi_home_pkg::LOOKUP : chi_home_pkg::ERROR;
        end
      end
      chi_home_pkg::LOOKUP: begin
        // Single cycle directory read
        state_nxt = snoop_needed ? chi_home_pkg::SNOOP : chi_home_pkg::COMPLETE;
      end
      chi_home_pkg::SNOOP: begin
        // snp_valid is high for the whole state
        if (snp_ready) begin
          state_nxt = chi_home_pkg::AWAIT_SNP;
        end
      end
      chi_home_pkg::AWAIT_SNP: begin
        // snp_resp_ready is high here
        if (snp_resp_valid) begin
          state_nxt = chi_home_pkg::COMPLETE;
        end
      end
      chi_home_pkg::COMPLETE: begin
        if (resp_ready) begin
          state_nxt = chi_home_pkg::IDLE;
        end
      end
      chi_home_pkg::ERROR: begin
        // No directory write on this path
        if (resp_ready) begin
          state_nxt = chi_home_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = chi_home_pkg::IDLE;
      end
    endcase
  end

  // Directory commits together with the completion handshake
  assign dir_update = (state == chi_home_pkg::COMPLETE) && resp_ready;

endmodule

//--- chi_resp_out.sv
`timescale 1ns/1ps
`include "chi_home_macros.svh"

module chi_resp_out (
  input  logic                          clk,
  input  logic                          rst_n,
  input  chi_home_pkg::chi_ctrl_state_e state,
  input  logic                          accept,
  // Captured request and directory results
  input  chi_home_pkg::chi_req_op_e     cur_op,
  input  logic [`CHI_TXN_W-1:0]         cur_txn_id,
  input  logic [`CHI_NODE_W-1:0]        cur_src_id,
  input  logic [`CHI_ADDR_W-1:0]        cur_addr,
  input  logic [`CHI_NUM_NODES-1:0]     snp_tgt_mask,
  input  logic                          dir_hit,
  input  chi_home_pkg::chi_line_state_e granted_state,
  input  logic                          resp_ready,
  // Snoop channel
  output logic                          snp_valid,
  output chi_home_pkg::chi_snp_op_e     snp_op,
  output logic [`CHI_TXN_W-1:0]         snp_txn_id,
  output logic [`CHI_ADDR_W-1:0]        snp_addr,
  output logic [`CHI_NUM_NODES-1:0]     snp_tgt_mask_out,
  output logic                          snp_resp_ready,
  // Response channel
  output logic                          resp_valid,
  output chi_home_pkg::chi_resp_op_e    resp_op,
  output logic [`CHI_TXN_W-1:0]         resp_txn_id,
  output logic [`CHI_NODE_W-1:0]        resp_tgt_id,
  output chi_home_pkg::chi_line_state_e resp_state,
  // Counters
  output logic [`CHI_CNT_W-1:0]         req_count,
  output logic [`CHI_CNT_W-1:0]         resp_count,
  output logic [`CHI_CNT_W-1:0]         hit_count,
  output logic [`CHI_CNT_W-1:0]         miss_count,
  output logic [`CHI_CNT_W-1:0]         err_count
);

  logic is_lookup;
  logic resp_hs;

  // ==============================
  // Snoop and response channels
  // ==============================

  // Fields come from registered state so they hold steady under back-pressure
  assign snp_valid        = (state == chi_home_pkg::SNOOP);
  assign snp_op           = (cur_op == chi_home_pkg::READ_UNIQUE) ?
                            chi_home_pkg::SNP_UNIQUE : chi_home_pkg::SNP_SHARED;
  assign snp_txn_id       = cur_txn_id;
  assign snp_addr         = cur_addr;
  assign snp_tgt_mask_out = snp_valid ? snp_tgt_mask : '0;
  assign snp_resp_ready   = (state == chi_home_pkg::AWAIT_SNP);

  always_comb begin
    resp_valid  = 1'b0;
    resp_op     = chi_home_pkg::COMP;
    resp_state  = chi_home_pkg::INVALID;
    resp_txn_id = cur_txn_id;
    resp_tgt_id = cur_src_id;
    if (state == chi_home_pkg::COMPLETE) begin
      resp_valid = 1'b1;
      resp_state = granted_state;
    end else if (state == chi_home_pkg::ERROR) begin
      // Out of window, nothing granted
      resp_valid = 1'b1;
      resp_op    = chi_home_pkg::COMP_ERR;
    end
  end

  assign is_lookup = (state == chi_home_pkg::LOOKUP);
  assign resp_hs   = resp_valid && resp_ready;

  // ==============================
  // Counters
  // ==============================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_count  <= '0;
      resp_count <= '0;
      hit_count  <= '0;
      miss_count <= '0;
      err_count  <= '0;
    end else begin
      if (accept) req_count <= req_count + 1'b1;
      if (resp_hs) resp_count <= resp_count + 1'b1;
      // One hit or miss per in-range request
      if (is_lookup && dir_hit) hit_count <= hit_count + 1'b1;
      if (is_lookup && !dir_hit) miss_count <= miss_count + 1'b1;
      if (resp_hs && state == chi_home_pkg::ERROR) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

endmodule

//--- chi_home_node.sv
`timescale 1ns/1ps
`include "chi_home_macros.svh"

module chi_home_node (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`CHI_ADDR_W-1:0]        base_addr,
  input  logic [`CHI_ADDR_W-1:0]        addr_mask,
  // Request channel
  input  logic                          req_valid,
  output logic                          req_ready,
  input  chi_home_pkg::chi_req_op_e     req_op,
  input  logic [`CHI_TXN_W-1:0]         req_txn_id,
  input  logic [`CHI_NODE_W-1:0]        req_src_id,
  input  logic [`CHI_ADDR_W-1:0]        req_addr,
  // Snoop channel and its response
  output logic                          snp_valid,
  input  logic                          snp_ready,
  output chi_home_pkg::chi_snp_op_e     snp_op,
  output logic [`CHI_TXN_W-1:0]         snp_txn_id,
  output logic [`CHI_ADDR_W-1:0]        snp_addr,
  output logic [`CHI_NUM_NODES-1:0]     snp_tgt_mask,
  input  logic                          snp_resp_valid,
  output logic                          snp_resp_ready,
  // Response channel
  output logic                          resp_valid,
  input  logic                          resp_ready,
  output chi_home_pkg::chi_resp_op_e    resp_op,
  output logic [`CHI_TXN_W-1:0]         resp_txn_id,
  output logic [`CHI_NODE_W-1:0]        resp_tgt_id,
  output chi_home_pkg::chi_line_state_e resp_state,
  // Counters
  output logic [`CHI_CNT_W-1:0]         req_count,
  output logic [`CHI_CNT_W-1:0]         resp_count,
  output logic [`CHI_CNT_W-1:0]         hit_count,
  output logic [`CHI_CNT_W-1:0]         miss_count,
  output logic [`CHI_CNT_W-1:0]         err_count
);

  // ==============================
  // Internal nets
  // ==============================

  chi_home_pkg::chi_ctrl_state_e state;
  chi_home_pkg::chi_req_op_e     cur_op;
  chi_home_pkg::chi_line_state_e granted_state;
  logic                          accept;
  logic                          in_range;
  logic [`CHI_TXN_W-1:0]         cur_txn_id;
  logic [`CHI_NODE_W-1:0]        cur_src_id;
  logic [`CHI_ADDR_W-1:0]        cur_addr;
  logic                          snoop_needed;
  logic                          dir_hit;
  logic                          dir_update;
  // Raw target mask from the directory
  logic [`CHI_NUM_NODES-1:0]     dir_tgt_mask;

  chi_req_intake u_intake (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (req_op),
    .req_txn_id (req_txn_id),
    .req_src_id (req_src_id),
    .req_addr   (req_addr),
    .base_addr  (base_addr),
    .addr_mask  (addr_mask),
    .state      (state),
    .accept     (accept),
    .in_range   (in_range),
    .cur_op     (cur_op),
    .cur_txn_id (cur_txn_id),
    .cur_src_id (cur_src_id),
    .cur_addr   (cur_addr)
  );

  chi_directory u_dir (
    .clk           (clk),
    .rst_n         (rst_n),
    .state         (state),
    .cur_op        (cur_op),
    .cur_src_id    (cur_src_id),
    .cur_addr      (cur_addr),
    .dir_update    (dir_update),
    .snoop_needed  (snoop_needed),
    .snp_tgt_mask  (dir_tgt_mask),
    .dir_hit       (dir_hit),
    .granted_state (granted_state)
  );

  chi_home_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .accept         (accept),
    .in_range       (in_range),
    .snoop_needed   (snoop_needed),
    .snp_ready      (snp_ready),
    .snp_resp_valid (snp_resp_valid),
    .resp_ready     (resp_ready),
    .state          (state),
    .dir_update     (dir_update)
  );

  chi_resp_out u_out (
    .clk              (clk),
    .rst_n            (rst_n),
    .state            (state),
    .accept           (accept),
    .cur_op           (cur_op),
    .cur_txn_id       (cur_txn_id),
    .cur_src_id       (cur_src_id),
    .cur_addr         (cur_addr),
    .snp_tgt_mask     (dir_tgt_mask),
    .dir_hit          (dir_hit),
    .granted_state    (granted_state),
    .resp_ready       (resp_ready),
    .snp_valid        (snp_valid),
    .snp_op           (snp_op),
    .snp_txn_id       (snp_txn_id),
    .snp_addr         (snp_addr),
    .snp_tgt_mask_out (snp_tgt_mask),
    .snp_resp_ready   (snp_resp_ready),
    .resp_valid       (resp_valid),
    .resp_op          (resp_op),
    .resp_txn_id      (resp_txn_id),
    .resp_tgt_id      (resp_tgt_id),
    .resp_state       (resp_state),
    .req_count        (req_count),
    .resp_count       (resp_count),
    .hit_count        (hit_count),
    .miss_count       (miss_count),
    .err_count        (err_count)
  );

endmodule

//--- chi_home_sva.sv
`timescale 1ns/1ps
`include "chi_home_macros.svh"

module chi_home_sva (
  input  logic                          clk,
  input  logic                          rst_n,
  // Request channel
  input  logic                          req_valid,
  input  logic                          req_ready,
  // Snoop channel
  input  logic                          snp_valid,
  input  logic                          snp_ready,
  input  chi_home_pkg::chi_snp_op_e     snp_op,
  input  logic [`CHI_TXN_W-1:0]         snp_txn_id,
  input  logic [`CHI_ADDR_W-1:0]        snp_addr,
  input  logic [`CHI_NUM_NODES-1:0]     snp_tgt_mask,
  input  logic                          snp_resp_ready,
  // Response channel
  input  logic                          resp_valid,
  input  logic                          resp_ready,
  input  chi_home_pkg::chi_resp_op_e    resp_op,
  input  logic [`CHI_TXN_W-1:0]         resp_txn_id,
  input  chi_home_pkg::chi_line_state_e resp_state
);

  // ==============================
  // Handshake rules
  // ==============================

  // Single transaction in flight, busy right after an accept
  a_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid && req_ready) |=> !req_ready)
    else $error("req_ready still high after an accept");

  // Busy until the response is taken
  a_busy_until_resp: assert property (@(posedge clk) disable iff (!rst_n)
    (!req_ready && !(resp_valid && resp_ready)) |=> !req_ready)
    else $error("req_ready rose before the response handshake");

  // Snoop held with steady fields until taken
  a_snp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (snp_valid && !snp_ready) |=> (snp_valid && $stable(snp_op) && $stable(snp_txn_id)
                                   && $stable(snp_addr) && $stable(snp_tgt_mask)))
    else $error("snoop dropped or changed before snp_ready");

  // Response held with steady fields until taken
  a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_op)
                                     && $stable(resp_txn_id) && $stable(resp_state)))
    else $error("response dropped or changed before resp_ready");

  // Quiet outputs right after a reset cycle
  a_reset_idle: assert property (@(posedge clk)
    !rst_n |=> (req_ready && !snp_valid && !resp_valid && !snp_resp_ready))
    else $error("control outputs active after reset");

endmodule

//--- tb_chi_home.sv
`timescale 1ns/1ps
`include "chi_home_macros.svh"

module tb_chi_home;

  localparam int NUM_TXN  = 400;
  localparam int WAIT_MAX = 100;
  localparam logic [`CHI_ADDR_W-1:0] BASE = 32'h8000_0000;
  localparam logic [`CHI_ADDR_W-1:0] OUTSIDE = 32'h4000_0000;

  logic                          clk;
  logic                          rst_n;
  logic [`CHI_ADDR_W-1:0]        base_addr;
  logic [`CHI_ADDR_W-1:0]        addr_mask;
  logic                          req_valid;
  logic                          req_ready;
  chi_home_pkg::chi_req_op_e     req_op;
  logic [`CHI_TXN_W-1:0]         req_txn_id;
  logic [`CHI_NODE_W-1:0]        req_src_id;
  logic [`CHI_ADDR_W-1:0]        req_addr;
  logic                          snp_valid;
  logic                          snp_ready;
  chi_home_pkg::chi_snp_op_e     snp_op;
  logic [`CHI_TXN_W-1:0]         snp_txn_id;
  logic [`CHI_ADDR_W-1:0]        snp_addr;
  logic [`CHI_NUM_NODES-1:0]     snp_tgt_mask;
  logic                          snp_resp_valid;
  logic                          snp_resp_ready;
  logic                          resp_valid;
  logic                          resp_ready;
  chi_home_pkg::chi_resp_op_e    resp_op;
  logic [`CHI_TXN_W-1:0]         resp_txn_id;
  logic [`CHI_NODE_W-1:0]        resp_tgt_id;
  chi_home_pkg::chi_line_state_e resp_state;
  logic [`CHI_CNT_W-1:0]         req_count;
  logic [`CHI_CNT_W-1:0]         resp_count;
  logic [`CHI_CNT_W-1:0]         hit_count;
  logic [`CHI_CNT_W-1:0]         miss_count;
  logic [`CHI_CNT_W-1:0]         err_count;

  // Directory model per line slot, out-of-range slots 6 and 7 never update it
  logic [`CHI_NUM_NODES-1:0]     m_sharers [0:7];
  chi_home_pkg::chi_line_state_e m_state   [0:7];
  logic                          m_valid   [0:7];
  int n_req, n_resp, n_hit, n_miss, n_err, n_snp_uniq, n_snp_shr;
  int errors;
  logic hung;
  logic [31:0] rng;

  chi_home_node i_dut (.*);

  bind chi_home_node chi_home_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .snp_valid      (snp_valid),
    .snp_ready      (snp_ready),
    .snp_op         (snp_op),
    .snp_txn_id     (snp_txn_id),
    .snp_addr       (snp_addr),
    .snp_tgt_mask   (snp_tgt_mask),
    .snp_resp_ready (snp_resp_ready),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_op        (resp_op),
    .resp_txn_id    (resp_txn_id),
    .resp_state     (resp_state)
  );

  always #5 clk = ~clk;

  // ==============================
  // Helpers and compare tasks
  // ==============================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic flag_failure(input string msg);
    errors++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  task automatic check_resp_op(input chi_home_pkg::chi_resp_op_e got, exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: resp_op %s, expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_snp_op(input chi_home_pkg::chi_snp_op_e got, exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: snp_op %s, expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_line_state(input chi_home_pkg::chi_line_state_e got, exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: resp_state %s, expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_count(input logic [`CHI_CNT_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Ids, masks, addresses and latencies
  task automatic check_field(input logic [31:0] got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // Random stalls on the three channels the testbench answers
  task automatic drive_backpressure();
    rng = xorshift(rng);
    snp_ready      = rng[0] | rng[1];
    snp_resp_valid = rng[2] | rng[3];
    resp_ready     = rng[4] | rng[5];
  endtask

  // ==============================
  // One transaction
  // ==============================

  task automatic run_txn();
    chi_home_pkg::chi_req_op_e op;
    logic [`CHI_NODE_W-1:0]    src;
    logic [`CHI_TXN_W-1:0]     txn;
    logic [`CHI_NUM_NODES-1:0] req_bit;
    logic [`CHI_NUM_NODES-1:0] exp_mask;
    logic [`CHI_ADDR_W-1:0]    addr;
    int   slot;
    int   cyc;
    logic in_rng;
    logic snp_taken;
    logic snp_done;
    logic seen_snp;
    logic seen_resp;
    logic done;
    rng  = xorshift(rng);
    op   = rng[0] ? chi_home_pkg::READ_UNIQUE : chi_home_pkg::READ_SHARED;
    src  = rng[3:1];
    slot = int'(rng[6:4]);
    txn  = rng[14:7];
    in_rng = (slot < 6);
    // Out-of-range lines alias directory indexes 0 and 1
    if (in_rng) begin
      addr = BASE + 32'(slot * 64);
    end else begin
      addr = OUTSIDE + 32'((slot - 6) * 64);
    end
    addr = addr + {26'd0, rng[20:15]};
    req_bit  = 8'd1 << src;
    exp_mask = '0;
    // Unique read hits every other copy, shared read only a unique owner
    if (in_rng && (op == chi_home_pkg::READ_UNIQUE ||
                   m_state[slot] == chi_home_pkg::UNIQUE_CLEAN)) begin
      exp_mask = m_sharers[slot] & ~req_bit;
    end
    req_valid  = 1'b1;
    req_op     = op;
    req_src_id = src;
    req_txn_id = txn;
    req_addr   = addr;
    cyc  = 0;
    done = 1'b0;
    while (!done && !hung) begin
      @(negedge clk);
      done = req_ready;
      cyc++;
      if (cyc > WAIT_MAX) begin
        hung = 1'b1;
        $display("Timeout: the request was never accepted");
      end
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
    n_req++;
    // Cycle count is measured from the accept edge
    cyc       = 0;
    snp_taken = 1'b0;
    snp_done  = 1'b0;
    seen_snp  = 1'b0;
    seen_resp = 1'b0;
    done      = hung;
    while (!done && !hung) begin
      drive_backpressure();
      @(negedge clk);
      cyc++;
      // Snoop goes out at T+2 and is held until taken
      check_field(snp_valid, (exp_mask != '0) && (cyc >= 2) && !snp_taken, "snp_valid");
      check_field(snp_resp_ready, snp_taken && !snp_done, "snp_resp_ready");
      if (snp_valid && !seen_snp) begin
        seen_snp = 1'b1;
        if (op == chi_home_pkg::READ_UNIQUE) begin
          n_snp_uniq++;
          check_snp_op(snp_op, chi_home_pkg::SNP_UNIQUE);
        end else begin
          n_snp_shr++;
          check_snp_op(snp_op, chi_home_pkg::SNP_SHARED);
        end
        check_field(snp_tgt_mask, exp_mask, "snp_tgt_mask");
        check_field(snp_txn_id, txn, "snp_txn_id");
        check_field(snp_addr, addr, "snp_addr");
      end
      if (resp_valid && !seen_resp) begin
        seen_resp = 1'b1;
        if (!in_rng) begin
          check_field(cyc, 1, "cycles from accept to error response");
          check_resp_op(resp_op, chi_home_pkg::COMP_ERR);
          check_line_state(resp_state, chi_home_pkg::INVALID);
        end else begin
          check_resp_op(resp_op, chi_home_pkg::COMP);
          check_line_state(resp_state, (op == chi_home_pkg::READ_UNIQUE) ?
                           chi_home_pkg::UNIQUE_CLEAN : chi_home_pkg::SHARED_CLEAN);
          if (exp_mask == '0) begin
            check_field(cyc, 2, "cycles from accept to response");
          end else if (!snp_done) begin
            flag_failure("completion came before the snoop response");
          end
        end
        check_field(resp_txn_id, txn, "resp_txn_id");
        check_field(resp_tgt_id, src, "resp_tgt_id");
      end
      done = resp_valid && resp_ready;
      if (snp_valid && snp_ready) begin
        snp_taken = 1'b1;
      end
      if (snp_resp_ready && snp_resp_valid) begin
        snp_done = 1'b1;
      end
      if (cyc > WAIT_MAX) begin
        hung = 1'b1;
        $display("Timeout: no completed response for txn id %0d", txn);
      end
      @(posedge clk);
      #1;
    end
    if (exp_mask != '0 && !seen_snp) begin
      flag_failure("an expected snoop was never issued");
    end
    // Model update mirrors the completion
    n_resp++;
    if (!in_rng) begin
      n_err++;
    end else begin
      if (m_valid[slot]) n_hit++;
      else n_miss++;
      m_valid[slot] = 1'b1;
      if (op == chi_home_pkg::READ_UNIQUE) begin
        m_sharers[slot] = req_bit;
        m_state[slot]   = chi_home_pkg::UNIQUE_CLEAN;
      end else begin
        m_sharers[slot] = m_sharers[slot] | req_bit;
        m_state[slot]   = chi_home_pkg::SHARED_CLEAN;
      end
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    int ntx;
    clk = 1'b0;
    rst_n = 1'b0;
    base_addr = BASE;
    addr_mask = 32'hFFFF_F000;
    req_valid = 1'b0;
    req_op = chi_home_pkg::READ_SHARED;
    req_txn_id = '0;
    req_src_id = '0;
    req_addr = '0;
    snp_ready = 1'b0;
    snp_resp_valid = 1'b0;
    resp_ready = 1'b0;
    rng = 32'hd02;
    errors = 0;
    hung = 1'b0;
    {n_req, n_resp, n_hit, n_miss, n_err, n_snp_uniq, n_snp_shr} = '0;
    for (int i = 0; i < 8; i++) begin
      m_sharers[i] = '0;
      m_state[i]   = chi_home_pkg::INVALID;
      m_valid[i]   = 1'b0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet after reset
    @(negedge clk);
    check_field(req_ready, 1, "req_ready after reset");
    check_field(resp_valid, 0, "resp_valid after reset");
    check_field(snp_valid, 0, "snp_valid after reset");
    check_count(req_count, 0, "req_count after reset");
    check_count(resp_count, 0, "resp_count after reset");
    check_count(hit_count, 0, "hit_count after reset");
    check_count(miss_count, 0, "miss_count after reset");
    check_count(err_count, 0, "err_count after reset");
    @(posedge clk);
    #1;
    for (ntx = 0; ntx < NUM_TXN && !hung; ntx++) begin
      run_txn();
      rng = xorshift(rng);
      repeat (int'(rng[1:0])) begin
        @(posedge clk);
        #1;
      end
    end
    @(negedge clk);
    check_count(req_count, n_req, "req_count");
    check_count(resp_count, n_resp, "resp_count");
    check_count(hit_count, n_hit, "hit_count");
    check_count(miss_count, n_miss, "miss_count");
    check_count(err_count, n_err, "err_count");
    if (n_snp_uniq == 0 || n_snp_shr == 0) begin
      flag_failure("random traffic did not produce both snoop kinds");
    end
    $display("Summary: %0d transactions, %0d errors, %0d timeouts", ntx, errors, hung);
    if (errors == 0 && !hung) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
chi_home_pkg.sv
chi_req_intake.sv
chi_directory.sv
chi_home_ctrl.sv
chi_resp_out.sv
chi_home_node.sv
chi_home_sva.sv
tb_chi_home.sv

//--- Makefile
# Verilator build and run of the home node testbench
VERILATOR ?= verilator
TOP       ?= tb_chi_home
FILELIST  ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK
FAIL_MSG  ?= Test FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
